//--- design/px_pkg.sv
package px_pkg;

	typedef logic [15:0] word_t;	// System bus address word
	typedef logic [3:0]  irq_num_t;	// Interrupt source number

	localparam word_t VECTOR_BASE = 16'h0040;	// Interrupt vector table
	localparam int    ALARM_TICKS = 32;	// No-reply limit in granted cycles
	localparam int    ALARM_CNT_W = $clog2(ALARM_TICKS + 1);

	typedef logic [ALARM_CNT_W-1:0] alarm_cnt_t;	// No-memory alarm counter

	// CPU major states
	typedef enum logic [3:0] {
		ST_K1,	// Instruction fetch
		ST_K2,	// Argument fetch
		ST_P,	// Address preparation, bus idle
		ST_WR,	// Operand read
		ST_WW,	// Operand write
		ST_WM,	// I/O transfer
		ST_I1,	// Vector read
		ST_I2,	// Push
		ST_I3,	// Push
		ST_I4,	// Read back
		ST_I5	// Final write
	} px_state_t;

	typedef enum logic [2:0] {
		OP_REG,	// Register only, no operand cycle
		OP_LOAD,
		OP_STORE,
		OP_IN,
		OP_OU
	} op_class_t;

	typedef struct packed {
		op_class_t op;	// Class from the instruction decoder
		logic      need_arg;	// Second word follows
	} px_instr_t;

	typedef struct packed {
		px_state_t st;	// Current major state
		op_class_t op;	// Class latched at end of K1
	} px_ctl_t;

	typedef struct packed {
		logic df;	// Fetch
		logic dr;	// Read
		logic dw;	// Write
		logic ds;	// Send
	} px_bus_t;

endpackage

//--- design/px_state_decode.sv
`timescale 1ns/1ps

module px_state_decode import px_pkg::*; (
	input  logic      __clk,
	input  logic      clo,
	input  logic      ldstate,	// Load strobe from sequencer
	input  px_instr_t instr,	// Sampled only with ldstate
	input  logic      irq,	// Sampled only with ldstate
	output px_ctl_t   ctl
);

	px_ctl_t   ctl_q;
	px_state_t st_d;
	op_class_t op_d;

	// Next-state decode
	always_comb begin
		st_d = ctl_q.st;	// Hold by default
		op_d = ctl_q.op;
		case (ctl_q.st)
			ST_K1: begin
				op_d = instr.op;	// Latch class with the fetched word
				st_d = instr.need_arg ? ST_K2 : ST_P;
			end
			ST_K2: st_d = ST_P;
			ST_P: begin
				case (ctl_q.op)
					OP_REG:   st_d = irq ? ST_I1 : ST_K1;
					OP_LOAD:  st_d = ST_WR;
					OP_STORE: st_d = ST_WW;
					OP_IN,
					OP_OU:    st_d = ST_WM;	// Both via I/O transfer
					default:  st_d = ST_K1;
				endcase
			end
			ST_WR,
			ST_WW,
			ST_WM: st_d = irq ? ST_I1 : ST_K1;	// End of instruction
			// Fixed interrupt sequence
			ST_I1: st_d = ST_I2;
			ST_I2: st_d = ST_I3;
			ST_I3: st_d = ST_I4;
			ST_I4: st_d = ST_I5;
			ST_I5: st_d = ST_K1;	// Back to fetch at handler
			default: st_d = ST_K1;
		endcase
	end

	// State register
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			ctl_q.st <= ST_K1;
			ctl_q.op <= OP_REG;
		end else if (ldstate) begin
			ctl_q.st <= st_d;
			ctl_q.op <= op_d;
		end
	end

	assign ctl = ctl_q;

endmodule

//--- design/px_strobgen.sv
`timescale 1ns/1ps

module px_strobgen (
	input  logic __clk,
	input  logic clo,
	input  logic bus_cycle,	// Current state uses the bus
	input  logic ok_done,	// Bus cycle finished (reply or alarm)
	output logic strob1,
	output logic strob2,
	output logic got,
	output logic ldstate
);

	// Each value names the pulse active in that cycle
	typedef enum logic [1:0] {
		S1,
		WAIT,
		S2,
		GOT
	} strob_st_t;

	strob_st_t fsm_q;
	strob_st_t fsm_d;

	always_comb begin
		fsm_d = fsm_q;
		case (fsm_q)
			S1:   fsm_d = bus_cycle ? WAIT : S2;	// No bus means no wait
			WAIT: fsm_d = ok_done ? S2 : WAIT;
			S2:   fsm_d = GOT;
			GOT:  fsm_d = S1;	// New state loads here
			default: fsm_d = S1;
		endcase
	end

	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			fsm_q <= GOT;	// First edge after release goes to S1
		end else begin
			fsm_q <= fsm_d;
		end
	end

	// Registered pulses, each high while fsm_q sits in its step
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			strob1 <= 1'b0;
			strob2 <= 1'b0;
			got    <= 1'b0;
		end else begin
			strob1 <= (fsm_d == S1);
			strob2 <= (fsm_d == S2);
			got    <= (fsm_d == GOT);
		end
	end

	assign ldstate = got;	// Same pulse, internal state load

endmodule

//--- design/px_ifctl.sv
`timescale 1ns/1ps

module px_ifctl import px_pkg::*; (
	input  logic __clk,
	input  logic clo,
	input  logic strob1,
	input  logic bus_cycle,
	input  logic zw,	// Bus grant
	input  logic rok,	// Reply pulse
	output logic zg,	// Bus request
	output logic zwzg,	// Request granted
	output logic ok_done,	// End of bus cycle
	output logic alarm,	// No-memory timeout pulse
	output logic awaria	// Sticky alarm flag
);

	alarm_cnt_t alarm_cnt;
	logic       timeout;

	assign zwzg    = zg & zw;
	assign timeout = (alarm_cnt == '0);
	assign alarm   = zwzg & ~rok & timeout;	// Reply wins a tie
	assign ok_done = (zwzg & rok) | alarm;

	// Bus request flip-flop
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			zg <= 1'b0;
		end else if (ok_done) begin
			zg <= 1'b0;	// Drop after reply or alarm
		end else if (strob1 && bus_cycle) begin
			zg <= 1'b1;
		end
	end

	// Alarm down-counter, runs only with grant held
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			alarm_cnt <= alarm_cnt_t'(ALARM_TICKS);
		end else if (!zg) begin
			alarm_cnt <= alarm_cnt_t'(ALARM_TICKS);	// Rearm between cycles
		end else if (zwzg && !timeout) begin
			alarm_cnt <= alarm_cnt - 1'b1;
		end
	end

	// Alarm latch, only reset clears it
	always_ff @(posedge __clk or posedge clo) begin
		if (clo) begin
			awaria <= 1'b0;
		end else if (alarm) begin
			awaria <= 1'b1;
		end
	end

endmodule

//--- design/px_busdrv.sv
`timescale 1ns/1ps

module px_busdrv import px_pkg::*; (
	input  px_ctl_t  ctl,
	input  logic     zwzg,	// Grant held
	input  word_t    ic,	// Instruction counter
	input  word_t    ar,	// Argument register
	input  irq_num_t irq_num,
	output logic     bus_cycle,
	output px_bus_t  bus,
	output word_t    dad
);

	px_bus_t cmd;
	word_t   addr;

	// Command table per state
	always_comb begin
		cmd  = '0;
		addr = ar;	// Most cycles use AR
		case (ctl.st)
			ST_K1,
			ST_K2: begin
				cmd.df = 1'b1;
				addr   = ic;	// Fetch at IC
			end
			ST_WR: cmd.dr = 1'b1;
			ST_WW: cmd.dw = 1'b1;
			ST_WM: begin
				cmd.df = (ctl.op == OP_IN);	// Input is a fetch
				cmd.ds = (ctl.op == OP_OU);
			end
			ST_I1: begin
				cmd.dr = 1'b1;
				addr   = VECTOR_BASE + {12'd0, irq_num};	// Vector slot
			end
			ST_I2,
			ST_I3,
			ST_I5: cmd.dw = 1'b1;
			ST_I4: cmd.dr = 1'b1;
			default: cmd = '0;	// P, no bus
		endcase
	end

	assign bus_cycle = |cmd;	// Ungated, seen by sequencer and ifctl
	assign bus       = zwzg ? cmd : '0;	// Drivers only under grant
	assign dad       = zwzg ? addr : '0;

endmodule

//--- design/px_unit.sv
`timescale 1ns/1ps

module px_unit import px_pkg::*; (
	input  logic      __clk,
	input  logic      clo,
	input  px_instr_t instr,
	input  logic      irq,
	input  irq_num_t  irq_num,
	input  word_t     ic,
	input  word_t     ar,
	input  logic      zw,
	input  logic      rok,
	output px_state_t state,
	output logic      strob1,
	output logic      strob2,
	output logic      got,
	output logic      ldstate,
	output logic      zg,
	output px_bus_t   bus,
	output word_t     dad,
	output logic      alarm,
	output logic      awaria
);

	px_ctl_t ctl;
	logic    bus_cycle;	// Current state needs the bus
	logic    zwzg;
	logic    ok_done;

	assign state = ctl.st;

	px_state_decode px_state_decode_inst (
		.__clk  (__clk),
		.clo    (clo),
		.ldstate(ldstate),
		.instr  (instr),
		.irq    (irq),
		.ctl    (ctl)
	);

	px_strobgen px_strobgen_inst (
		.__clk    (__clk),
		.clo      (clo),
		.bus_cycle(bus_cycle),
		.ok_done  (ok_done),
		.strob1   (strob1),
		.strob2   (strob2),
		.got      (got),
		.ldstate  (ldstate)
	);

	px_ifctl px_ifctl_inst (
		.__clk    (__clk),
		.clo      (clo),
		.strob1   (strob1),
		.bus_cycle(bus_cycle),
		.zw       (zw),
		.rok      (rok),
		.zg       (zg),
		.zwzg     (zwzg),
		.ok_done  (ok_done),
		.alarm    (alarm),
		.awaria   (awaria)
	);

	px_busdrv px_busdrv_inst (
		.ctl      (ctl),
		.zwzg     (zwzg),
		.ic       (ic),
		.ar       (ar),
		.irq_num  (irq_num),
		.bus_cycle(bus_cycle),
		.bus      (bus),
		.dad      (dad)
	);

endmodule

//--- testbench/px_checker.sv
`timescale 1ns/1ps

module px_checker import px_pkg::*; (
	input  logic      __clk,
	input  logic      clo,
	input  px_instr_t instr,
	input  logic      irq,
	input  irq_num_t  irq_num,
	input  word_t     ic,
	input  word_t     ar,
	input  logic      zw,
	input  logic      rok,
	input  px_state_t state,
	input  logic      strob1,
	input  logic      strob2,
	input  logic      got,
	input  logic      ldstate,
	input  logic      zg,
	input  px_bus_t   bus,
	input  word_t     dad,
	input  logic      alarm,
	input  logic      awaria,
	input  logic      finish,
	output int        errors
);

	px_state_t ref_st;
	op_class_t ref_op;
	logic      exp_awaria;
	int        gcount;	// Granted cycles in current request
	int        p_cyc;
	int        checks;
	int        alarms;
	logic      prev_zg, prev_strob1, prev_busst, prev_end;

	function automatic px_state_t ref_next_state(px_state_t st, op_class_t op,
			px_instr_t in, logic ir);
		case (st)
			ST_K1: return in.need_arg ? ST_K2 : ST_P;
			ST_K2: return ST_P;
			ST_P: begin
				if (op == OP_LOAD) return ST_WR;
				if (op == OP_STORE) return ST_WW;
				if (op == OP_IN || op == OP_OU) return ST_WM;
				return ir ? ST_I1 : ST_K1;
			end
			ST_WR, ST_WW, ST_WM: return ir ? ST_I1 : ST_K1;
			ST_I1: return ST_I2;
			ST_I2: return ST_I3;
			ST_I3: return ST_I4;
			ST_I4: return ST_I5;
			default: return ST_K1;
		endcase
	endfunction

	// Command lines df,dr,dw,ds then address
	function automatic logic [19:0] ref_bus_cmd(px_state_t st, op_class_t op,
			word_t a_ic, word_t a_ar, irq_num_t n);
		case (st)
			ST_K1, ST_K2: return {4'b1000, a_ic};
			ST_WR, ST_I4: return {4'b0100, a_ar};
			ST_WW, ST_I2, ST_I3, ST_I5: return {4'b0010, a_ar};
			ST_WM: return {(op == OP_IN) ? 4'b1000 : 4'b0001, a_ar};
			ST_I1: return {4'b0100, 16'h0040 + word_t'(n)};
			default: return {4'b0000, a_ar};	// P idle
		endcase
	endfunction

	task automatic report_mismatch(string msg);
		errors++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	always @(negedge __clk) begin
		logic [19:0] exp;
		logic        zwzg;
		logic        exp_alarm;
		logic        cyc_end;
		checks++;
		if (clo) begin
			if (state != ST_K1 || strob1 || strob2 || got || ldstate || zg || alarm ||
					awaria || bus != '0 || dad != '0)
				report_mismatch("outputs not idle during reset");
			ref_st = ST_K1;
			ref_op = OP_REG;
			exp_awaria = 1'b0;
			gcount = 0;
			p_cyc = 0;
			{prev_zg, prev_strob1, prev_busst, prev_end} = '0;
		end else begin
			exp  = ref_bus_cmd(ref_st, ref_op, ic, ar, irq_num);
			zwzg = zg & zw;
			if (state != ref_st)
				report_mismatch($sformatf("state %s expected %s",
					state.name(), ref_st.name()));
			if (ref_st == ST_P) begin	// Three strobes back to back
				if (zg)
					report_mismatch("bus request in P");
				if (strob1 != (p_cyc == 0) || strob2 != (p_cyc == 1) ||
						ldstate != (p_cyc == 2) || got != (p_cyc == 2))
					report_mismatch($sformatf("P strobe order wrong at step %0d", p_cyc));
				p_cyc++;
			end else begin
				p_cyc = 0;
			end
			if (zg && !prev_zg && !(prev_strob1 && prev_busst))
				report_mismatch("zg rose without strob1 in a bus state");
			if (!zg && prev_zg && !prev_end)
				report_mismatch("zg dropped without rok or alarm");
			if (zwzg) begin
				if ({bus, dad} != exp)
					report_mismatch($sformatf("bus %b dad %h expected %b %h in %s",
						bus, dad, exp[19:16], exp[15:0], ref_st.name()));
				exp_alarm = (gcount == ALARM_TICKS) && !rok;
			end else begin
				if (bus != '0 || dad != '0)
					report_mismatch($sformatf("bus %b dad %h driven without grant", bus, dad));
				exp_alarm = 1'b0;
			end
			if (alarm != exp_alarm)
				report_mismatch($sformatf("alarm %b expected %b", alarm, exp_alarm));
			if (awaria != exp_awaria)
				report_mismatch($sformatf("awaria %b expected %b", awaria, exp_awaria));
			if (exp_alarm)
				exp_awaria = 1'b1;	// Sticky until reset
			if (alarm)
				alarms++;
			cyc_end = (zwzg && rok) || exp_alarm;
			if (!zg || cyc_end)
				gcount = 0;
			else if (zwzg)
				gcount++;
			prev_zg     = zg;
			prev_strob1 = strob1;
			prev_busst  = (exp[19:16] != 4'b0000);
			prev_end    = cyc_end;
			if (ldstate) begin	// Inputs sampled only here
				if (ref_st == ST_K1)
					ref_op = instr.op;
				ref_st = ref_next_state(ref_st, ref_op, instr, irq);
			end
		end
	end

	initial begin
		errors = 0;
		checks = 0;
		alarms = 0;
	end

	always @(posedge finish)
		$display("Cycles checked: %0d, alarms seen: %0d, errors: %0d", checks, alarms, errors);

endmodule

//--- testbench/tb_px.sv
`timescale 1ns/1ps

module tb_px import px_pkg::*; ();

	localparam int N_TRANS = 400;	// State loads to run
	localparam int CLK_NS  = 20;

	logic      __clk;
	logic      clo;
	px_instr_t instr;
	logic      irq;
	irq_num_t  irq_num;
	word_t     ic;
	word_t     ar;
	logic      zw;
	logic      rok;
	px_state_t state;
	logic      strob1, strob2, got, ldstate;
	logic      zg, alarm, awaria;
	px_bus_t   bus;
	word_t     dad;
	logic      finish_chk;
	int        errors;
	int        trans_cnt;

	logic [31:0] lfsr;
	logic [1:0]  rsp_mode;	// 0 idle, 1 grant wait, 2 reply wait
	logic [1:0]  gcnt;
	logic [2:0]  rcnt;
	logic        no_reply;

	// Fibonacci LFSR, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic        nb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			nb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], nb};
			v    = {v[30:0], nb};
		end
		return v;
	endfunction

	initial begin
		__clk = 1'b0;
		forever #(CLK_NS / 2) __clk = ~__clk;
	end

	px_unit px_unit_inst (
		.__clk(__clk), .clo(clo), .instr(instr), .irq(irq), .irq_num(irq_num),
		.ic(ic), .ar(ar), .zw(zw), .rok(rok), .state(state),
		.strob1(strob1), .strob2(strob2), .got(got), .ldstate(ldstate),
		.zg(zg), .bus(bus), .dad(dad), .alarm(alarm), .awaria(awaria)
	);

	px_checker px_checker_inst (
		.__clk(__clk), .clo(clo), .instr(instr), .irq(irq), .irq_num(irq_num),
		.ic(ic), .ar(ar), .zw(zw), .rok(rok), .state(state),
		.strob1(strob1), .strob2(strob2), .got(got), .ldstate(ldstate),
		.zg(zg), .bus(bus), .dad(dad), .alarm(alarm), .awaria(awaria),
		.finish(finish_chk), .errors(errors)
	);

	// Stimulus and bus responder
	always @(posedge __clk) begin
		logic [31:0] r;
		if (!clo) begin
			if (got) begin	// New state starts, redraw inputs
				trans_cnt <= trans_cnt + 1;
				r = lfsr_bits(3);
				instr.op <= op_class_t'(r % 5);
				r = lfsr_bits(1);
				instr.need_arg <= r[0];
				r = lfsr_bits(2);
				irq <= (r[1:0] == 2'b11);	// About one in four
				r = lfsr_bits(4);
				irq_num <= irq_num_t'(r);
				r = lfsr_bits(16);
				ic <= word_t'(r);
				r = lfsr_bits(16);
				ar <= word_t'(r);
			end
			case (rsp_mode)
				2'd0: if (zg) begin
					r = lfsr_bits(2);
					gcnt <= r[1:0];	// Grant delay
					r = lfsr_bits(3);
					rcnt <= 3'(r % 6 + 1);	// Reply delay
					r = lfsr_bits(4);
					no_reply <= (r[3:0] == 4'd0);	// Provoke alarm
					rsp_mode <= 2'd1;
				end
				2'd1: if (gcnt == 0) begin
					zw       <= 1'b1;
					rsp_mode <= 2'd2;
				end else begin
					gcnt <= gcnt - 1'b1;
				end
				default: if (!zg || rok) begin	// Cycle ended
					zw       <= 1'b0;
					rok      <= 1'b0;
					rsp_mode <= 2'd0;
				end else if (!no_reply) begin
					if (rcnt <= 1)
						rok <= 1'b1;
					else
						rcnt <= rcnt - 1'b1;
				end
			endcase
		end
	end

	initial begin
		lfsr       = 32'ha5833606;
		clo        = 1'b1;
		instr      = '0;
		irq        = 1'b0;
		irq_num    = '0;
		ic         = '0;
		ar         = '0;
		zw         = 1'b0;
		rok        = 1'b0;
		finish_chk = 1'b0;
		trans_cnt  = 0;
		rsp_mode   = 2'd0;
		gcnt       = '0;
		rcnt       = '0;
		no_reply   = 1'b0;
		repeat (5) @(posedge __clk);
		clo <= 1'b0;
		wait (trans_cnt >= N_TRANS);
		@(posedge __clk);
		finish_chk <= 1'b1;	// Checker prints its summary
		@(posedge __clk);
		#1;
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Watchdog sized from worst case per state
	initial begin
		#(N_TRANS * (ALARM_TICKS + 20) * CLK_NS);
		$display("Timeout: the run did not finish %0d state loads in time", N_TRANS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- sim.f
design/px_pkg.sv
design/px_state_decode.sv
design/px_strobgen.sv
design/px_ifctl.sv
design/px_busdrv.sv
design/px_unit.sv
testbench/px_checker.sv
testbench/tb_px.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_px
FILELIST  := sim.f
FLAGS     := --binary --timing -j 0
LINTFLAGS := --lint-only --timing
OBJDIR    := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJDIR)
